// ==== audio_lab_top.f ====
audio_lab_pkg.sv
i2s_clock_gen.sv
i2s_mic_receiver.sv
audio_control_regs.sv
audio_processor.sv
i2s_audio_out.sv
seven_seg_hex.sv
audio_lab_top.sv
tb_audio_lab.sv

// ==== Makefile ====
# Verilator lint and simulation of the audio lab

TB = tb_audio_lab

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f audio_lab_top.f --top-module audio_lab_top

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing -Wno-fatal -f audio_lab_top.f --top-module $(TB)
	@out=$$(./obj_dir/V$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

// ==== tb_audio_lab.sv ====
// Each row takes about two I2S frames; the display is read over one scan after the frame start
module tb_audio_lab
    import audio_lab_pkg::*;
();

    typedef struct packed {
        logic [15:0]        keys;  // Press counts {clear, mute, down, up}
        logic               sw;
        logic               rnd;   // Expected values come from the model
        logic [mic_w-1:0]   word;
        logic [snd_w-1:0]   snd;
        logic [w_led-1:0]   led;
        logic [snd_w-1:0]   disp;
    } row_t;

    typedef struct packed {
        logic [snd_w-1:0] snd;
        logic [w_led-1:0] led;
    } expect_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [w_key-1:0]   key;
    logic               sw;
    logic               mic_sd = 1'b0;
    logic               mic_sck;
    logic               mic_ws;
    logic               mclk;
    logic               bclk;
    logic               lrclk;
    logic               sdata;
    logic [w_led-1:0]   led;
    logic [7:0]         abcdefgh;
    logic [w_digit-1:0] digit;

    row_t             rows[$];
    string            names[$];
    logic [31:0]      lcg_state = 32'he26984b1;
    bit               table_done = 1'b0;
    int               errors = 0;
    int               frame_cnt = 0;
    logic [mic_w-1:0] mic_word;
    logic             prev_sck = 1'b0;
    logic             prev_ws = 1'b0;
    logic             mic_lr = 1'b0;
    int               mic_idx = 0;
    logic             prev_bclk = 1'b0;
    logic             dec_lr = 1'b0;
    int               dec_idx = -1;  // First rise after reset is slot bit 0
    logic [snd_w-1:0] dec_shift = '0;
    logic [snd_w-1:0] dec_left = '0;
    logic [snd_w-1:0] dec_right = '0;
    int               dec_count = 0;
    logic             prev_mclk = 1'b0;
    int               mclk_rises = 0;

    audio_lab_top audio_lab_top_inst (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sw       ( sw       ),
        .mic_sd   ( mic_sd   ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mclk     ( mclk     ),
        .bclk     ( bclk     ),
        .lrclk    ( lrclk    ),
        .sdata    ( sdata    ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    always #10 clk = ~clk;

    // ------------------------------------------------
    // Microphone model and frame monitor

    always @(posedge clk) begin
        if (prev_sck && !mic_sck) begin  // mic_sck fell at the last edge
            if (mic_ws != mic_lr) begin
                mic_lr  = mic_ws;
                mic_idx = 0;
            end else begin
                mic_idx++;
            end
            if (!mic_ws && mic_idx >= 1 && mic_idx <= mic_w)
                mic_sd <= #2 mic_word[mic_w - mic_idx];  // MSB first from slot bit 1
            else
                mic_sd <= #2 1'b0;
        end
        if (prev_ws && !mic_ws)
            frame_cnt <= frame_cnt + 1;  // Left slot has begun
        prev_sck <= mic_sck;
        prev_ws  <= mic_ws;
    end

    // ------------------------------------------------
    // Master clock monitor

    always @(posedge clk) begin
        if (!prev_mclk && mclk)
            mclk_rises <= mclk_rises + 1;  // Rising mclk at the last edge
        prev_mclk <= mclk;
    end

    // ------------------------------------------------
    // I2S output decoder

    always @(posedge clk) begin
        if (!prev_bclk && bclk) begin  // Rising bclk at the last edge
            if (lrclk != dec_lr) begin
                dec_lr  = lrclk;
                dec_idx = 0;
            end else begin
                dec_idx++;
            end
            if (dec_idx >= 1 && dec_idx <= snd_w)
                dec_shift = {dec_shift[snd_w-2:0], sdata};
            if (dec_idx == snd_w) begin
                if (lrclk) begin
                    dec_right = dec_shift;
                    dec_count++;
                end else begin
                    dec_left = dec_shift;
                end
            end
        end
        prev_bclk <= bclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Gain shift, 16-bit clip, mute, level bar against 2**(12+k)
    function automatic expect_t process_model(logic [mic_w-1:0] word, int gain, bit mute);
        int      scaled;
        int      mag;
        expect_t r;

        scaled = $signed(word);
        scaled = scaled >>> (gain_max - gain);
        r.led  = '0;
        if (scaled > 32767) begin
            scaled   = 32767;
            r.led[3] = 1'b1;
        end else if (scaled < -32768) begin
            scaled   = -32768;
            r.led[3] = 1'b1;
        end
        if (mute) begin
            scaled = 0;
            r.led  = '0;
        end
        r.snd = 16'(scaled);
        mag   = (scaled < 0) ? -scaled : scaled;
        for (int k = 0; k < 3; k++)
            r.led[k] = mag >= (1 << (level_base + k));
        return r;
    endfunction

    function automatic logic [4:0] seg_to_hex(logic [7:0] seg);
        case (seg)
            8'hfc: return 5'h0;
            8'h60: return 5'h1;
            8'hda: return 5'h2;
            8'hf2: return 5'h3;
            8'h66: return 5'h4;
            8'hb6: return 5'h5;
            8'hbe: return 5'h6;
            8'he0: return 5'h7;
            8'hfe: return 5'h8;
            8'hf6: return 5'h9;
            8'he6: return 5'h9;  // Nine without the d segment
            8'hee: return 5'ha;
            8'h3e: return 5'hb;
            8'h9c: return 5'hc;
            8'h7a: return 5'hd;
            8'h9e: return 5'he;
            8'h8e: return 5'hf;
            default: return 5'h10;  // Not a hex digit
        endcase
    endfunction

    task automatic add_row(string name, logic [15:0] keys, logic sw_in, logic [mic_w-1:0] word,
                           logic [snd_w-1:0] snd, logic [w_led-1:0] led_in,
                           logic [snd_w-1:0] disp);
        names.push_back(name);
        rows.push_back({keys, sw_in, 1'b0, word, snd, led_in, disp});
    endtask

    task automatic build_table();
        logic [31:0] rnd_word;

        //     name              keys      sw    word        sound     led    display
        add_row("gain4_pos",      16'h0000, 1'b0, 24'h012345, 16'h1234, 4'h1, 16'h1234);
        add_row("gain4_neg",      16'h0000, 1'b0, 24'hfedcba, 16'hedcb, 4'h1, 16'h1235);
        add_row("gain_up_sat",    16'h0005, 1'b0, 24'h123456, 16'h7fff, 4'hf, 16'h7fff);
        add_row("gain8_neg_clip", 16'h0000, 1'b0, 24'h800000, 16'h8000, 4'hf, 16'h8000);
        add_row("gain_down_sat",  16'h00a0, 1'b0, 24'h7fffff, 16'h7fff, 4'h7, 16'h8000);
        add_row("gain0_small",    16'h0000, 1'b1, 24'h000f00, 16'h000f, 4'h0, 16'h000f);
        add_row("peak_clear",     16'h1004, 1'b0, 24'h050000, 16'h5000, 4'h7, 16'h5000);
        add_row("mute_on",        16'h0100, 1'b0, 24'h050000, 16'h0000, 4'h0, 16'h5000);
        add_row("mute_off",       16'h0100, 1'b1, 24'hfb0000, 16'hb000, 4'h7, 16'hb000);
        add_row("level_neg_2",    16'h0000, 1'b0, 24'hfe0000, 16'he000, 4'h3, 16'h5000);
        add_row("level_pos_1",    16'h0000, 1'b1, 24'h01fff0, 16'h1fff, 4'h1, 16'h1fff);
        add_row("level_neg_0",    16'h0000, 1'b1, 24'hff0010, 16'hf001, 4'h0, 16'hf001);
        add_row("level_neg_3",    16'h0000, 1'b0, 24'hfc0000, 16'hc000, 4'h7, 16'h5000);
        for (int n = 0; n < 5; n++) begin
            rnd_word = lcg_next();
            names.push_back($sformatf("random_%0d", n));
            rows.push_back({16'h0000, n[0], 1'b1, rnd_word[mic_w-1:0], 36'h0});
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_frame();
        int start;

        start = frame_cnt;
        do
            next_cycle();
        while (frame_cnt == start);
    endtask

    task automatic press_key(key_cmd_e cmd);
        key[cmd] = 1'b1;
        repeat (4) next_cycle();
        key[cmd] = 1'b0;
        repeat (4) next_cycle();
    endtask

    // Scan period equals one frame, so 900 cycles after the frame start see every digit
    task automatic read_display(output logic [snd_w-1:0] value, output bit ok);
        logic [3:0] seen;
        logic [4:0] nib;
        int         d;

        seen  = '0;
        value = '0;
        ok    = 1'b1;
        repeat (900) begin
            next_cycle();
            case (digit)
                4'b0001: d = 0;
                4'b0010: d = 1;
                4'b0100: d = 2;
                4'b1000: d = 3;
                default: d = -1;
            endcase
            nib = seg_to_hex(abcdefgh);
            if (d < 0 || nib[4]) begin
                ok = 1'b0;
            end else begin
                value[d*4 +: 4] = nib[3:0];
                seen[d]         = 1'b1;
            end
        end
        if (seen != 4'hf)
            ok = 1'b0;
    endtask

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    // ------------------------------------------------
    // Watchdog

    initial begin
        wait (table_done);
        #(rows.size() * 3 * frame_cycles * 20 + 4 * 20);
        $display("Timeout: the run did not finish in time, the DUT or testbench is stuck");
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------------------------
    // Test sequence

    initial begin
        row_t             r;
        expect_t          res;
        logic [snd_w-1:0] mag;
        logic [snd_w-1:0] disp_val;
        bit               disp_ok;
        int               gain_model;
        bit               mute_model;
        logic [snd_w-1:0] peak_model;
        int               errs_before;
        int               dec_start;
        int               mclk_start;
        int               passed;

        rst_n      = 1'b0;
        key        = '0;
        sw         = 1'b0;
        mic_word   = '0;
        passed     = 0;
        gain_model = gain_reset;
        mute_model = 1'b0;
        peak_model = '0;
        build_table();
        table_done = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            wait_frame();  // Frame in which the mic sends the word
            mclk_start = mclk_rises;
            mic_word   = r.word;
            sw         = r.sw;
            for (int n = 0; n < int'(r.keys[3:0]); n++) begin
                press_key(gain_up);
                if (gain_model < gain_max)
                    gain_model++;
            end
            for (int n = 0; n < int'(r.keys[7:4]); n++) begin
                press_key(gain_down);
                if (gain_model > 0)
                    gain_model--;
            end
            for (int n = 0; n < int'(r.keys[11:8]); n++) begin
                press_key(mute_toggle);
                mute_model = !mute_model;
            end
            for (int n = 0; n < int'(r.keys[15:12]); n++) begin
                press_key(peak_clear);
                peak_model = '0;
            end

            if (r.rnd) begin
                res   = process_model(r.word, gain_model, mute_model);
                r.snd = res.snd;
                r.led = res.led;
            end
            mag = r.snd[snd_w-1] ? -r.snd : r.snd;
            if (mag > peak_model)
                peak_model = mag;
            if (r.rnd)
                r.disp = r.sw ? r.snd : peak_model;

            wait_frame();  // Stat now holds the word
            errs_before = errors;
            dec_start   = dec_count;
            // One full frame has passed since the count was taken
            check_value(names[i], "mclk rises", 32'(frame_cycles / mclk_div),
                        32'(mclk_rises - mclk_start));
            check_value(names[i], "led", 32'(r.led), 32'(led));
            read_display(disp_val, disp_ok);
            if (!disp_ok) begin
                $display("%s: display digits could not be read from the scan", names[i]);
                errors++;
            end else begin
                check_value(names[i], "display", 32'(r.disp), 32'(disp_val));
            end
            if (dec_count == dec_start) begin
                $display("%s: no output frame was decoded from sdata", names[i]);
                errors++;
            end else begin
                check_value(names[i], "left", 32'(r.snd), 32'(dec_left));
                check_value(names[i], "right", 32'(r.snd), 32'(dec_right));
            end

            if (errors == errs_before) begin
                passed++;
                $display("%s: ok", names[i]);
            end else begin
                $display("%s: %0d errors", names[i], errors - errs_before);
            end
        end

        $display("%0d tests, %0d passed, %0d failed", rows.size(), passed,
                 rows.size() - passed);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== audio_lab_top.sv ====
// Outputs are active high; the mic shares bclk and lrclk with the codec, left slot only
module audio_lab_top
    import audio_lab_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [w_key-1:0]   key,
    input  logic               sw,
    input  logic               mic_sd,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mclk,
    output logic               bclk,
    output logic               lrclk,
    output logic               sdata,
    output logic [w_led-1:0]   led,
    output logic [7:0]         abcdefgh,
    output logic [w_digit-1:0] digit
);

    i2s_clk_t                clks;
    logic signed [mic_w-1:0] mic_sample;
    logic                    mic_valid;
    audio_ctrl_t             ctrl;
    audio_stat_t             stat;
    logic [snd_w-1:0]        disp_value;

    //------------------------------------------------
    // Audio path

    i2s_clock_gen i2s_clock_gen_inst (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .clks  ( clks  )
    );

    i2s_mic_receiver i2s_mic_receiver_inst (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .clks         ( clks       ),
        .sd           ( mic_sd     ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  )
    );

    audio_control_regs audio_control_regs_inst (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .key   ( key   ),
        .sw    ( sw    ),
        .ctrl  ( ctrl  )
    );

    audio_processor audio_processor_inst (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  ),
        .ctrl         ( ctrl       ),
        .stat         ( stat       )
    );

    i2s_audio_out i2s_audio_out_inst (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .clks   ( clks        ),
        .sample ( stat.sample ),
        .sdata  ( sdata       )
    );

    //------------------------------------------------
    // Board outputs

    assign mic_sck = clks.bclk;
    assign mic_ws  = clks.lrclk;
    assign mclk    = clks.mclk;
    assign bclk    = clks.bclk;
    assign lrclk   = clks.lrclk;

    assign led        = {stat.clip, stat.level};  // Clip above the bar
    assign disp_value = (ctrl.disp_mode == show_sample) ? stat.sample : stat.peak;

    seven_seg_hex seven_seg_hex_inst (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .value    ( disp_value ),
        .abcdefgh ( abcdefgh   ),
        .digit    ( digit      )
    );

endmodule

// ==== seven_seg_hex.sv ====
// Active-high segments and digits, a is the MSB, decimal point always off, digit 0 rightmost
module seven_seg_hex
    import audio_lab_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [snd_w-1:0]   value,
    output logic [7:0]         abcdefgh,
    output logic [w_digit-1:0] digit
);

    logic [scan_cnt_w-1:0]  scan_cnt;
    logic [$clog2(w_digit)-1:0] sel;
    logic [3:0]             nibble;

    always_ff @(posedge clk) begin
        if (!rst_n)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // Upper counter bits step once every scan_div cycles
    assign sel    = scan_cnt[scan_cnt_w-1 -: $clog2(w_digit)];
    assign digit  = w_digit'(1) << sel;
    assign nibble = value[sel * 4 +: 4];

    //------------------------------------------------
    // Hex to segments

    always_comb begin
        case (nibble)
            4'h0: abcdefgh = 8'b11111100;
            4'h1: abcdefgh = 8'b01100000;
            4'h2: abcdefgh = 8'b11011010;
            4'h3: abcdefgh = 8'b11110010;
            4'h4: abcdefgh = 8'b01100110;
            4'h5: abcdefgh = 8'b10110110;
            4'h6: abcdefgh = 8'b10111110;
            4'h7: abcdefgh = 8'b11100000;
            4'h8: abcdefgh = 8'b11111110;
            4'h9: abcdefgh = 8'b11100110;
            4'ha: abcdefgh = 8'b11101110;
            4'hb: abcdefgh = 8'b00111110;  // Lower case b
            4'hc: abcdefgh = 8'b10011100;
            4'hd: abcdefgh = 8'b01111010;  // Lower case d
            4'he: abcdefgh = 8'b10011110;
            default: abcdefgh = 8'b10001110;  // F
        endcase
    end

endmodule

// ==== i2s_audio_out.sv ====
// Same 16-bit sample on both channels, left-justified in 32-bit slots, standard one-bit delay
module i2s_audio_out
    import audio_lab_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  i2s_clk_t         clks,
    input  logic [snd_w-1:0] sample,
    output logic             sdata
);

    logic                  load_q;
    logic [snd_w-1:0]      hold;
    logic [snd_w-1:0]      shift_q;
    logic [slot_cnt_w-1:0] bit_cnt;
    logic [slot_cnt_w-1:0] bit_nxt;

    //------------------------------------------------
    // Frame latch

    // Processor updates its stat the cycle after frame_start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            hold   <= '0;
        end else begin
            load_q <= clks.frame_start;
            if (load_q)
                hold <= sample;
        end
    end

    //------------------------------------------------
    // Slot serializer

    // Slot bit that begins at this bclk fall
    assign bit_nxt = clks.frame_start ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            shift_q <= '0;
            sdata   <= 1'b0;
        end else if (clks.bit_fall) begin
            bit_cnt <= bit_nxt;  // Wraps at the lrclk edge
            if (bit_nxt == 1) begin
                sdata   <= hold[snd_w-1];
                shift_q <= hold << 1;
            end else begin
                // Empties after 16 bits, so the slot tail is zero
                sdata   <= shift_q[snd_w-1];
                shift_q <= shift_q << 1;
            end
        end
    end

endmodule

// ==== audio_processor.sv ====
// Gain is a right shift by gain_max - gain; a clear with a sample in the same cycle keeps that sample
module audio_processor
    import audio_lab_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic signed [mic_w-1:0] sample,
    input  logic                    sample_valid,
    input  audio_ctrl_t             ctrl,
    output audio_stat_t             stat
);

    logic [gain_w-1:0]       shamt;
    logic signed [mic_w-1:0] scaled;
    logic signed [snd_w-1:0] sat;
    logic                    sat_clip;
    logic signed [snd_w-1:0] out_smp;
    logic                    out_clip;
    logic [snd_w-1:0]        mag;
    logic [level_w-1:0]      level;
    logic [snd_w-1:0]        peak_base;
    logic [snd_w-1:0]        peak_next;

    //------------------------------------------------
    // Gain, saturation and mute

    always_comb begin
        shamt  = gain_w'(gain_max) - ctrl.gain;
        scaled = sample >>> shamt;  // Sign kept

        if (scaled > snd_max) begin
            sat      = snd_w'(snd_max);
            sat_clip = 1'b1;
        end else if (scaled < snd_min) begin
            sat      = snd_w'(snd_min);
            sat_clip = 1'b1;
        end else begin
            sat      = scaled[snd_w-1:0];
            sat_clip = 1'b0;
        end

        out_smp  = ctrl.mute ? '0 : sat;
        out_clip = sat_clip && !ctrl.mute;
    end

    //------------------------------------------------
    // Magnitude, level bar and peak

    always_comb begin
        // -32768 maps to 0x8000, still exact as unsigned
        mag = out_smp[snd_w-1] ? snd_w'(-out_smp) : snd_w'(out_smp);

        for (int k = 0; k < level_w; k++) begin
            level[k] = 32'(mag) >= (32'd1 << (level_base + k));
        end

        peak_base = ctrl.peak_clear ? '0 : stat.peak;
        peak_next = (mag > peak_base) ? mag : peak_base;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stat <= '0;
        end else if (sample_valid) begin
            stat.sample <= out_smp;
            stat.level  <= level;
            stat.clip   <= out_clip;
            stat.peak   <= peak_next;
        end else if (ctrl.peak_clear) begin
            stat.peak   <= '0;  // Next sample sets it again
        end
    end

endmodule

// ==== audio_control_regs.sv ====
// Keys are active-high levels and count once per press; no debounce beyond the synchronizer
module audio_control_regs
    import audio_lab_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [w_key-1:0] key,
    input  logic             sw,
    output audio_ctrl_t      ctrl
);

    logic [w_key-1:0]  key_meta;
    logic [w_key-1:0]  key_sync;
    logic [w_key-1:0]  key_prev;
    logic [w_key-1:0]  key_rise;
    logic              sw_meta;
    logic              sw_sync;
    logic [gain_w-1:0] gain_q;
    logic              mute_q;
    logic              pclr_q;
    disp_mode_e        disp_q;

    //------------------------------------------------
    // Synchronizers and edge detect

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
            sw_meta  <= 1'b0;
            sw_sync  <= 1'b0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
            sw_meta  <= sw;
            sw_sync  <= sw_meta;
        end
    end

    assign key_rise = key_sync & ~key_prev;

    //------------------------------------------------
    // Control registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gain_q <= gain_w'(gain_reset);
            mute_q <= 1'b0;
            pclr_q <= 1'b0;
            disp_q <= show_peak;
        end else begin
            if (key_rise[gain_up] && gain_q < gain_w'(gain_max))
                gain_q <= gain_q + 1'b1;
            else if (key_rise[gain_down] && gain_q != '0)
                gain_q <= gain_q - 1'b1;

            if (key_rise[mute_toggle])
                mute_q <= !mute_q;

            pclr_q <= key_rise[peak_clear];  // Single cycle
            disp_q <= sw_sync ? show_sample : show_peak;
        end
    end

    always_comb begin
        ctrl.gain       = gain_q;
        ctrl.mute       = mute_q;
        ctrl.peak_clear = pclr_q;
        ctrl.disp_mode  = disp_q;
    end

endmodule

// ==== i2s_mic_receiver.sv ====
// Left slot only, 24 bits from slot bit 1; the sample is valid only while sample_valid is high
module i2s_mic_receiver
    import audio_lab_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  i2s_clk_t                clks,
    input  logic                    sd,
    output logic signed [mic_w-1:0] sample,
    output logic                    sample_valid
);

    logic                  sd_meta;
    logic                  sd_sync;
    logic [slot_cnt_w-1:0] bit_cnt;
    logic [mic_w-1:0]      shift_q;
    logic                  in_word;

    // Pin is asynchronous to clk
    always_ff @(posedge clk) begin
        sd_meta <= sd;
        sd_sync <= sd_meta;
    end

    //------------------------------------------------
    // Bit position within the slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (clks.frame_start) begin
            bit_cnt <= '0;
        end else if (clks.bit_fall) begin
            bit_cnt <= bit_cnt + 1'b1;  // Wraps into the right slot
        end
    end

    // I2S data starts one bit after the word clock edge
    assign in_word = !clks.lrclk && bit_cnt >= 1 && bit_cnt <= mic_w;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (clks.bit_rise && in_word) begin
            shift_q <= {shift_q[mic_w-2:0], sd_sync};  // MSB first
        end
    end

    // Word stays put until bit 1 of the next left slot
    assign sample       = shift_q;
    assign sample_valid = clks.frame_start;

endmodule

// ==== i2s_clock_gen.sv ====
// All I2S clocks come from one counter; the first frame after reset has no frame_start
module i2s_clock_gen
    import audio_lab_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output i2s_clk_t clks
);

    logic [frame_cnt_w-1:0] cnt;
    logic                   bit_rise_q;
    logic                   bit_fall_q;
    logic                   frame_q;

    //------------------------------------------------
    // Counter and registered strobes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= '0;
            bit_rise_q <= 1'b0;
            bit_fall_q <= 1'b0;
            frame_q    <= 1'b0;
        end else begin
            cnt        <= cnt + 1'b1;
            // Strobes line up with the counter value after this edge
            bit_rise_q <= cnt[$clog2(bclk_div)-1:0] == bclk_div / 2 - 1;
            bit_fall_q <= cnt[$clog2(bclk_div)-1:0] == bclk_div - 1;
            frame_q    <= cnt == frame_cnt_w'(frame_cycles - 1);
        end
    end

    always_comb begin
        clks.mclk        = cnt[$clog2(mclk_div)-1];
        clks.bclk        = cnt[$clog2(bclk_div)-1];  // Low 8 cycles, then high 8
        clks.lrclk       = cnt[frame_cnt_w-1];       // Flips on a bclk fall
        clks.bit_rise    = bit_rise_q;
        clks.bit_fall    = bit_fall_q;
        clks.frame_start = frame_q;
    end

endmodule

// ==== audio_lab_pkg.sv ====
// Sizes are fixed for one board clock with an INMP441-style mic and a 16-bit I2S codec
package audio_lab_pkg;

    //------------------------------------------------
    // Widths

    localparam int mic_w   = 24;  // Microphone word
    localparam int snd_w   = 16;  // Codec sample
    localparam int w_key   = 4;
    localparam int w_led   = 4;
    localparam int w_digit = 4;

    //------------------------------------------------
    // Clock ratios

    localparam int bclk_div     = 16;  // clk cycles per bit clock
    localparam int mclk_div     = 4;   // clk cycles per master clock
    localparam int slot_bits    = 32;  // Bit clocks per channel slot
    localparam int frame_cycles = 2 * slot_bits * bclk_div;
    localparam int frame_cnt_w  = $clog2(frame_cycles);
    localparam int slot_cnt_w   = $clog2(slot_bits);

    //------------------------------------------------
    // Gain and output range

    localparam int gain_w     = 4;
    localparam int gain_max   = 8;  // No shift at top gain
    localparam int gain_reset = 4;
    localparam int snd_max    = 2 ** (snd_w - 1) - 1;
    localparam int snd_min    = -(2 ** (snd_w - 1));

    //------------------------------------------------
    // Level bar and display

    localparam int level_base = 12;         // LED 0 threshold is 2**12
    localparam int level_w    = w_led - 1;  // Top LED is the clip flag
    localparam int scan_div   = 256;        // clk cycles per digit
    localparam int scan_cnt_w = $clog2(scan_div * w_digit);

    typedef enum logic {show_peak, show_sample} disp_mode_e;

    // Value is the key index that issues the command
    typedef enum logic [1:0] {gain_up, gain_down, mute_toggle, peak_clear} key_cmd_e;

    typedef struct packed {
        logic mclk;
        logic bclk;
        logic lrclk;        // Low for the left slot
        logic bit_rise;     // bclk has just gone high
        logic bit_fall;     // bclk has just gone low
        logic frame_start;  // Fall that opens the left slot
    } i2s_clk_t;

    typedef struct packed {
        logic [gain_w-1:0] gain;
        logic              mute;
        logic              peak_clear;  // One cycle pulse
        disp_mode_e        disp_mode;
    } audio_ctrl_t;

    typedef struct packed {
        logic signed [snd_w-1:0] sample;
        logic [snd_w-1:0]        peak;   // Absolute value
        logic [level_w-1:0]      level;  // Thermometer code
        logic                    clip;
    } audio_stat_t;

endpackage
